// File: logic/usb_pkg.sv
`default_nettype none

package usb_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Packet identifiers and FSM states
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        PID_OUT   = 4'b0001,
        PID_IN    = 4'b1001,
        PID_SETUP = 4'b1101,
        PID_DATA0 = 4'b0011,
        PID_DATA1 = 4'b1011,
        PID_DATA2 = 4'b0111,
        PID_MDATA = 4'b1111,
        PID_ACK   = 4'b0010,
        PID_NAK   = 4'b1010,
        PID_STALL = 4'b1110,
        PID_NYET  = 4'b0110,
        PID_PRE   = 4'b1100,
        PID_SOF   = 4'b0101,
        PID_PING  = 4'b0100,
        PID_SPLIT = 4'b1000
    } usb_pid_e;

    typedef enum logic [2:0] {
        RX_IDLE, RX_PID, RX_TOKEN, RX_DATA, RX_WAIT_EOP
    } rx_state_e;

    typedef enum logic [2:0] {
        TX_IDLE, TX_PID, TX_PAYLOAD, TX_CRC_LO, TX_CRC_HI, TX_EOP
    } tx_state_e;

    typedef enum logic [1:0] {
        LS_SE0 = 2'b00,
        LS_J   = 2'b01,
        LS_K   = 2'b10,
        LS_SE1 = 2'b11
    } line_state_e;

    // UTMI receive side, straight from the PHY
    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       active;
        logic       error;
    } utmi_rx_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       sop;
        logic       eop;
    } rx_byte_t;

    typedef struct packed {
        usb_pid_e   pid;
        logic [6:0] dev_addr;
        logic [3:0] endp;
        logic       crc_valid;
    } token_info_t;

    typedef struct packed {
        logic [7:0] data;
        logic       valid;
        logic       eop;
    } tx_byte_t;

    localparam logic [4:0]  CRC5_INIT  = 5'b11111;
    localparam logic [15:0] CRC16_INIT = 16'hffff;
    localparam logic [4:0]  CRC5_POLY  = 5'b00101;    // x^5 + x^2 + 1
    localparam logic [15:0] CRC16_POLY = 16'h8005;    // x^16 + x^15 + x^2 + 1

    // Line timing in 60 MHz clocks
    localparam int unsigned SE0_RESET_CYCLES = 150;      // 2.5 us
    localparam int unsigned SUSPEND_CYCLES   = 180000;   // 3 ms

    typedef logic [$clog2(SE0_RESET_CYCLES + 1)-1:0] se0_cnt_t;
    typedef logic [$clog2(SUSPEND_CYCLES + 1)-1:0]   idle_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // PID classes and CRC steps
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic pid_is_token(input usb_pid_e pid);
        return pid inside {PID_OUT, PID_IN, PID_SETUP, PID_PING, PID_SOF};
    endfunction

    function automatic logic pid_is_data(input usb_pid_e pid);
        return pid inside {PID_DATA0, PID_DATA1, PID_DATA2, PID_MDATA};
    endfunction

    // LSB first; nbits below 8 covers the 3-bit tail of a token
    function automatic logic [4:0] crc5_byte(input logic [4:0] crc, input logic [7:0] data,
                                             input int unsigned nbits = 8);
        logic [4:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            if (i < nbits) begin
                c = (data[i] ^ c[4]) ? ({c[3:0], 1'b0} ^ CRC5_POLY) : {c[3:0], 1'b0};
            end
        end
        return c;
    endfunction

    function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] data);
        logic [15:0] c;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            c = (data[i] ^ c[15]) ? ({c[14:0], 1'b0} ^ CRC16_POLY) : {c[14:0], 1'b0};
        end
        return c;
    endfunction

    // Wire order of the token CRC, complemented, bit 4 lands in byte bit 3
    function automatic logic [4:0] crc5_field(input logic [4:0] crc);
        return ~{crc[0], crc[1], crc[2], crc[3], crc[4]};
    endfunction

endpackage

`default_nettype wire

// File: logic/usb_rx_decoder.sv
`default_nettype none

module usb_rx_decoder (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire usb_pkg::utmi_rx_t  utmi_rx,
    output usb_pkg::rx_byte_t       rx_byte,
    output usb_pkg::token_info_t    rx_info
);

    usb_pkg::rx_state_e state;
    usb_pkg::usb_pid_e  pid_q;
    logic [6:0]         addr_q;
    logic [3:0]         endp_q;
    logic [4:0]         crc5_q;
    logic [15:0]        crc16_q;
    logic [7:0]         dly0;       // Newest data byte
    logic [7:0]         dly1;
    logic [1:0]         dly_cnt;
    logic               tok_ok;
    logic               in_pkt;     // Between sop and eop, survives an rx error

    logic               accept;
    logic               pkt_start;
    logic               pkt_end;
    logic               data_ok;
    logic               pkt_ok;
    logic [4:0]         crc5_full;

    assign accept    = utmi_rx.valid && utmi_rx.active;
    assign pkt_start = accept && !in_pkt;
    assign pkt_end   = in_pkt && !utmi_rx.active;

    // Token tail is only endp[3:1], three bits of CRC input
    assign crc5_full = usb_pkg::crc5_byte(crc5_q, utmi_rx.data, 3);

    // The last two bytes held back are the CRC16, low byte first
    assign data_ok = (dly_cnt == 2'd2) && ({dly0, dly1} == ~crc16_q);

    always_comb begin
        case (state)
            usb_pkg::RX_PID:      pkt_ok = !usb_pkg::pid_is_token(pid_q) &&
                                           !usb_pkg::pid_is_data(pid_q);
            usb_pkg::RX_DATA:     pkt_ok = data_ok;
            usb_pkg::RX_WAIT_EOP: pkt_ok = tok_ok;
            default:              pkt_ok = 1'b0;    // Truncated or aborted
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // Control and output stream
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= usb_pkg::RX_IDLE;
            in_pkt  <= 1'b0;
            tok_ok  <= 1'b0;
            dly_cnt <= 2'd0;
            rx_byte <= '0;
            rx_info <= '0;
        end else begin
            rx_byte.data  <= utmi_rx.data;
            rx_byte.valid <= accept;
            rx_byte.sop   <= pkt_start;
            rx_byte.eop   <= pkt_end;

            case (state)
                usb_pkg::RX_IDLE: begin
                    if (pkt_start) begin
                        tok_ok  <= 1'b0;
                        dly_cnt <= 2'd0;
                        state   <= usb_pkg::RX_PID;
                    end
                end
                usb_pkg::RX_PID: begin
                    if (accept) begin
                        if (usb_pkg::pid_is_token(pid_q)) begin
                            state <= usb_pkg::RX_TOKEN;
                        end else if (usb_pkg::pid_is_data(pid_q)) begin
                            dly_cnt <= 2'd1;
                            state   <= usb_pkg::RX_DATA;
                        end else begin
                            state <= usb_pkg::RX_WAIT_EOP;   // Handshake too long
                        end
                    end
                end
                usb_pkg::RX_TOKEN: begin
                    if (accept) begin
                        tok_ok <= (utmi_rx.data[7:3] == usb_pkg::crc5_field(crc5_full));
                        state  <= usb_pkg::RX_WAIT_EOP;
                    end
                end
                usb_pkg::RX_DATA: begin
                    if (accept && dly_cnt != 2'd2) begin
                        dly_cnt <= dly_cnt + 2'd1;
                    end
                end
                default: ;
            endcase

            if (pkt_end) begin
                rx_info.pid       <= pid_q;
                rx_info.dev_addr  <= addr_q;
                rx_info.endp      <= endp_q;
                rx_info.crc_valid <= pkt_ok;
                in_pkt            <= 1'b0;
                state             <= usb_pkg::RX_IDLE;
            end else if (pkt_start) begin
                in_pkt <= 1'b1;
            end

            if (utmi_rx.error) begin
                state <= usb_pkg::RX_IDLE;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Field capture and CRC accumulation
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        case (state)
            usb_pkg::RX_IDLE: begin
                if (pkt_start) begin
                    pid_q   <= usb_pkg::usb_pid_e'(utmi_rx.data[3:0]);
                    crc5_q  <= usb_pkg::CRC5_INIT;
                    crc16_q <= usb_pkg::CRC16_INIT;
                end
            end
            usb_pkg::RX_PID: begin
                if (accept) begin
                    crc5_q    <= usb_pkg::crc5_byte(crc5_q, utmi_rx.data);
                    addr_q    <= utmi_rx.data[6:0];
                    endp_q[0] <= utmi_rx.data[7];
                    dly0      <= utmi_rx.data;
                end
            end
            usb_pkg::RX_TOKEN: begin
                if (accept) begin
                    endp_q[3:1] <= utmi_rx.data[2:0];
                end
            end
            usb_pkg::RX_DATA: begin
                if (accept) begin
                    if (dly_cnt == 2'd2) begin
                        crc16_q <= usb_pkg::crc16_byte(crc16_q, dly1);   // Now known payload
                    end
                    dly1 <= dly0;
                    dly0 <= utmi_rx.data;
                end
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

// File: logic/usb_tx_encoder.sv
`default_nettype none

module usb_tx_encoder (
    input  wire                     clk,
    input  wire                     rst_n,
    input  wire                     tx_start,
    input  wire usb_pkg::usb_pid_e  tx_pid,
    input  wire usb_pkg::tx_byte_t  tx_payload,
    output logic                    tx_payload_ready,
    input  wire                     utmi_tx_ready,
    output logic [7:0]              utmi_tx_data,
    output logic                    utmi_tx_valid
);

    usb_pkg::tx_state_e state;
    usb_pkg::usb_pid_e  pid_q;
    logic [4:0]         crc5_q;
    logic [15:0]        crc16_q;
    logic               tok_second;     // Next token byte carries the CRC5

    logic               is_token;
    logic               has_payload;
    logic               take;
    logic               load;
    logic [4:0]         crc5_full;

    assign is_token    = usb_pkg::pid_is_token(pid_q);
    assign has_payload = is_token || usb_pkg::pid_is_data(pid_q);
    assign take        = utmi_tx_valid && utmi_tx_ready;

    // Refill the output byte as it leaves, so a prompt source keeps valid high
    assign tx_payload_ready =
        (state == usb_pkg::TX_PID && has_payload && utmi_tx_ready) ||
        (state == usb_pkg::TX_PAYLOAD && (utmi_tx_ready || !utmi_tx_valid));

    assign load      = tx_payload.valid && tx_payload_ready;
    assign crc5_full = usb_pkg::crc5_byte(crc5_q, tx_payload.data, 3);

    ////////////////////////////////////////////////////////////////////////////
    // FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= usb_pkg::TX_IDLE;
            utmi_tx_valid <= 1'b0;
            tok_second    <= 1'b0;
        end else begin
            case (state)
                usb_pkg::TX_IDLE: begin
                    if (tx_start) begin
                        utmi_tx_valid <= 1'b1;
                        tok_second    <= 1'b0;
                        state         <= usb_pkg::TX_PID;
                    end
                end
                usb_pkg::TX_PID: begin
                    if (utmi_tx_ready) begin
                        utmi_tx_valid <= 1'b0;  // Refilled below if a byte is loaded
                        state <= has_payload ? usb_pkg::TX_PAYLOAD : usb_pkg::TX_EOP;
                    end
                end
                usb_pkg::TX_PAYLOAD: begin
                    if (take) begin
                        utmi_tx_valid <= 1'b0;
                    end
                end
                usb_pkg::TX_CRC_LO: begin
                    if (take) begin
                        state <= usb_pkg::TX_CRC_HI;
                    end
                end
                usb_pkg::TX_CRC_HI: begin
                    if (take) begin
                        state <= usb_pkg::TX_EOP;
                    end
                end
                usb_pkg::TX_EOP: begin
                    if (take) begin
                        utmi_tx_valid <= 1'b0;
                    end else if (!utmi_tx_valid) begin
                        state <= usb_pkg::TX_IDLE;     // One idle cycle marks EOP
                    end
                end
                default: state <= usb_pkg::TX_IDLE;
            endcase

            if (load) begin
                utmi_tx_valid <= 1'b1;
                if (is_token) begin
                    tok_second <= 1'b1;
                    if (tok_second) begin
                        state <= usb_pkg::TX_EOP;
                    end
                end else if (tx_payload.eop) begin
                    state <= usb_pkg::TX_CRC_LO;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Output byte and CRC
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (state == usb_pkg::TX_IDLE && tx_start) begin
            pid_q        <= tx_pid;
            utmi_tx_data <= {~tx_pid, tx_pid};
            crc5_q       <= usb_pkg::CRC5_INIT;
            crc16_q      <= usb_pkg::CRC16_INIT;
        end

        if (load) begin
            if (is_token && tok_second) begin
                utmi_tx_data <= {usb_pkg::crc5_field(crc5_full), tx_payload.data[2:0]};
            end else begin
                utmi_tx_data <= tx_payload.data;
            end
            crc5_q  <= usb_pkg::crc5_byte(crc5_q, tx_payload.data);
            crc16_q <= usb_pkg::crc16_byte(crc16_q, tx_payload.data);
        end

        // Complemented CRC16 goes out low byte first
        if (state == usb_pkg::TX_CRC_LO && take) begin
            utmi_tx_data <= ~crc16_q[7:0];
        end
        if (state == usb_pkg::TX_CRC_HI && take) begin
            utmi_tx_data <= ~crc16_q[15:8];
        end
    end

endmodule

`default_nettype wire

// File: logic/usb_line_monitor.sv
`default_nettype none

module usb_line_monitor (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire usb_pkg::line_state_e  line_state,
    output logic                       reset_detect,
    output logic                       suspend_detect,
    output logic                       resume_detect
);

    usb_pkg::se0_cnt_t  se0_cnt;
    usb_pkg::idle_cnt_t idle_cnt;

    logic se0_full;
    logic idle_full;

    assign se0_full  = (se0_cnt == usb_pkg::se0_cnt_t'(usb_pkg::SE0_RESET_CYCLES));
    assign idle_full = (idle_cnt == usb_pkg::idle_cnt_t'(usb_pkg::SUSPEND_CYCLES));

    // Both counters saturate at their threshold
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            se0_cnt  <= '0;
            idle_cnt <= '0;
        end else begin
            if (line_state != usb_pkg::LS_SE0) begin
                se0_cnt <= '0;
            end else if (!se0_full) begin
                se0_cnt <= se0_cnt + 1'b1;
            end

            if (line_state != usb_pkg::LS_J) begin
                idle_cnt <= '0;
            end else if (!idle_full) begin
                idle_cnt <= idle_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reset_detect   <= 1'b0;
            suspend_detect <= 1'b0;
            resume_detect  <= 1'b0;
        end else begin
            reset_detect  <= (line_state == usb_pkg::LS_SE0) && se0_full;
            resume_detect <= suspend_detect && (line_state == usb_pkg::LS_K);

            if (line_state == usb_pkg::LS_J && idle_full) begin
                suspend_detect <= 1'b1;
            end else if (line_state == usb_pkg::LS_K) begin
                suspend_detect <= 1'b0;     // Resume signalling
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/usb_protocol_top.sv
`default_nettype none

module usb_protocol_top (
    input  wire                        clk,
    input  wire                        rst_n,

    // UTMI side
    input  wire usb_pkg::utmi_rx_t     utmi_rx,
    input  wire usb_pkg::line_state_e  utmi_line_state,
    input  wire                        utmi_tx_ready,
    output wire [7:0]                  utmi_tx_data,
    output wire                        utmi_tx_valid,

    // User side
    input  wire                        tx_start,
    input  wire usb_pkg::usb_pid_e     tx_pid,
    input  wire usb_pkg::tx_byte_t     tx_payload,
    output wire                        tx_payload_ready,
    output wire usb_pkg::rx_byte_t     rx_byte,
    output wire usb_pkg::token_info_t  rx_info,

    output wire                        reset_detect,
    output wire                        suspend_detect,
    output wire                        resume_detect
);

    usb_rx_decoder u_rx (
        .clk     (clk),
        .rst_n   (rst_n),
        .utmi_rx (utmi_rx),
        .rx_byte (rx_byte),
        .rx_info (rx_info)
    );

    usb_tx_encoder u_tx (
        .clk              (clk),
        .rst_n            (rst_n),
        .tx_start         (tx_start),
        .tx_pid           (tx_pid),
        .tx_payload       (tx_payload),
        .tx_payload_ready (tx_payload_ready),
        .utmi_tx_ready    (utmi_tx_ready),
        .utmi_tx_data     (utmi_tx_data),
        .utmi_tx_valid    (utmi_tx_valid)
    );

    usb_line_monitor u_line (
        .clk            (clk),
        .rst_n          (rst_n),
        .line_state     (utmi_line_state),
        .reset_detect   (reset_detect),
        .suspend_detect (suspend_detect),
        .resume_detect  (resume_detect)
    );

endmodule

`default_nettype wire

// File: testbench/usb_checker.sv
`default_nettype none

module usb_checker (
    input  wire                        clk,
    input  wire usb_pkg::rx_byte_t     rx_byte,
    input  wire usb_pkg::token_info_t  rx_info,
    input  wire [7:0]                  utmi_tx_data,
    input  wire                        utmi_tx_valid,
    input  wire                        utmi_tx_ready
);

    logic [8:0]           rx_q[$];      // {sop, data}
    usb_pkg::token_info_t info_q[$];
    logic                 fields_q[$];  // Address and endpoint are meaningful
    logic [7:0]           tx_q[$];

    int    err_cnt  = 0;
    int    pass_cnt = 0;
    int    fail_cnt = 0;
    int    err_mark = 0;
    string test_name = "none";

    logic [8:0]           exp_rx;
    usb_pkg::token_info_t exp_info;
    logic                 exp_fields;
    logic [7:0]           exp_tx;

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic expect_rx(input logic sop, input logic [7:0] data);
        rx_q.push_back({sop, data});
    endtask

    task automatic expect_info(input usb_pkg::token_info_t info, input logic fields);
        info_q.push_back(info);
        fields_q.push_back(fields);
    endtask

    task automatic expect_tx(input logic [7:0] data);
        tx_q.push_back(data);
    endtask

    task automatic check_val(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s %s is %0h, expected %0h", $time, test_name, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic finish_test();
        if (rx_q.size() != 0 || info_q.size() != 0 || tx_q.size() != 0) begin
            $display("%s: packet incomplete, %0d rx bytes, %0d rx packets, %0d tx bytes missing",
                     test_name, rx_q.size(), info_q.size(), tx_q.size());
            err_cnt++;
            rx_q.delete();
            info_q.delete();
            fields_q.delete();
            tx_q.delete();
        end
        if (err_cnt == err_mark) begin
            pass_cnt++;
            $display("test %-24s passed", test_name);
        end else begin
            fail_cnt++;
            $display("test %-24s failed", test_name);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Receive stream and packet info
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rx_byte.valid) begin
            if (rx_q.size() == 0) begin
                $display("%s: received a byte that no packet accounts for", test_name);
                err_cnt++;
            end else begin
                exp_rx = rx_q.pop_front();
                check_val("rx byte {sop,data}", {rx_byte.sop, rx_byte.data}, exp_rx);
            end
        end
        if (rx_byte.eop) begin
            if (info_q.size() == 0) begin
                $display("%s: end of packet seen with no packet expected", test_name);
                err_cnt++;
            end else begin
                exp_info   = info_q.pop_front();
                exp_fields = fields_q.pop_front();
                check_val("pid", rx_info.pid, exp_info.pid);
                check_val("crc_valid", rx_info.crc_valid, exp_info.crc_valid);
                if (exp_fields) begin
                    check_val("dev_addr", rx_info.dev_addr, exp_info.dev_addr);
                    check_val("endp", rx_info.endp, exp_info.endp);
                end
            end
        end
    end

    // Bytes the PHY accepts
    always @(posedge clk) begin
        if (utmi_tx_valid && utmi_tx_ready) begin
            if (tx_q.size() == 0) begin
                $display("%s: an extra byte was transmitted", test_name);
                err_cnt++;
            end else begin
                exp_tx = tx_q.pop_front();
                check_val("tx byte", utmi_tx_data, exp_tx);
            end
        end
    end

endmodule

`default_nettype wire

// File: testbench/tb_usb_protocol.sv
`default_nettype none

module tb_usb_protocol;

    logic                  clk = 1'b0;
    logic                  rst_n;
    usb_pkg::utmi_rx_t     utmi_rx;
    usb_pkg::line_state_e  line_state;
    logic                  utmi_tx_ready;
    logic                  tx_start;
    usb_pkg::usb_pid_e     tx_pid;
    usb_pkg::tx_byte_t     tx_payload;
    logic [7:0]            utmi_tx_data;
    logic                  utmi_tx_valid;
    logic                  tx_payload_ready;
    usb_pkg::rx_byte_t     rx_byte;
    usb_pkg::token_info_t  rx_info;
    logic                  reset_detect;
    logic                  suspend_detect;
    logic                  resume_detect;

    integer     seed = 32'h74ff;
    logic       stall_en = 1'b0;
    logic [7:0] payload[$];
    logic [7:0] pkt[$];         // Expected wire bytes with the PID first

    always #4 clk = ~clk;

    usb_protocol_top UUT (
        .clk              (clk),
        .rst_n            (rst_n),
        .utmi_rx          (utmi_rx),
        .utmi_line_state  (line_state),
        .utmi_tx_ready    (utmi_tx_ready),
        .utmi_tx_data     (utmi_tx_data),
        .utmi_tx_valid    (utmi_tx_valid),
        .tx_start         (tx_start),
        .tx_pid           (tx_pid),
        .tx_payload       (tx_payload),
        .tx_payload_ready (tx_payload_ready),
        .rx_byte          (rx_byte),
        .rx_info          (rx_info),
        .reset_detect     (reset_detect),
        .suspend_detect   (suspend_detect),
        .resume_detect    (resume_detect)
    );

    usb_checker u_checker (
        .clk           (clk),
        .rx_byte       (rx_byte),
        .rx_info       (rx_info),
        .utmi_tx_data  (utmi_tx_data),
        .utmi_tx_valid (utmi_tx_valid),
        .utmi_tx_ready (utmi_tx_ready)
    );

    // PHY model stalls at random only while a transmit test runs
    always @(posedge clk) begin
        #1;
        utmi_tx_ready = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    end

    initial begin
        #((usb_pkg::SUSPEND_CYCLES + 20000) * 8);
        $display("Timeout: the run did not finish in the expected time");
        $display("** FAIL **");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference packet builders
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [4:0] ref_crc5(input logic [10:0] bits);
        logic [4:0] c;
        c = 5'h1f;
        for (int i = 0; i < 11; i++) begin
            c = {c[3:0], 1'b0} ^ ((bits[i] ^ c[4]) ? 5'b00101 : 5'b0);
        end
        return c;
    endfunction

    function automatic logic [15:0] ref_crc16();
        logic [15:0] c;
        c = 16'hffff;
        foreach (payload[k]) begin
            for (int i = 0; i < 8; i++) begin
                c = {c[14:0], 1'b0} ^ ((payload[k][i] ^ c[15]) ? 16'h8005 : 16'h0);
            end
        end
        return c;
    endfunction

    function automatic void build_token(input logic [3:0] pid, input logic [6:0] addr,
                                        input logic [3:0] endp);
        logic [4:0] c;
        c = ref_crc5({endp, addr});
        pkt.delete();
        pkt.push_back({~pid, pid});
        pkt.push_back({endp[0], addr});
        pkt.push_back({~c[0], ~c[1], ~c[2], ~c[3], ~c[4], endp[3:1]});
    endfunction

    function automatic void build_data(input logic [3:0] pid);
        logic [15:0] c;
        c = ref_crc16();
        pkt.delete();
        pkt.push_back({~pid, pid});
        foreach (payload[k]) begin
            pkt.push_back(payload[k]);
        end
        pkt.push_back(~c[7:0]);
        pkt.push_back(~c[15:8]);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic rx_send(input string name, input usb_pkg::token_info_t info,
                           input logic fields, input int err_at);
        u_checker.start_test(name);
        foreach (pkt[i]) begin
            u_checker.expect_rx(i == 0, pkt[i]);
        end
        u_checker.expect_info(info, fields);
        foreach (pkt[i]) begin
            @(posedge clk);
            #1 utmi_rx = '{data: pkt[i], valid: 1'b1, active: 1'b1, error: (i == err_at)};
        end
        @(posedge clk);
        #1 utmi_rx = '0;
        repeat (3) @(posedge clk);      // eop lands one cycle after active falls
        u_checker.finish_test();
    endtask

    task automatic rx_token(input usb_pkg::usb_pid_e pid, input logic corrupt, input int err_at);
        logic [6:0] addr;
        logic [3:0] endp;
        addr = $random(seed);
        endp = $random(seed);
        build_token(pid, addr, endp);
        if (corrupt) begin
            pkt[2][7] = ~pkt[2][7];
        end
        rx_send($sformatf("rx token %s%s", pid.name(), corrupt ? " bad crc" : (err_at > 0 ?
                " error" : "")), '{pid: pid, dev_addr: addr, endp: endp,
                crc_valid: !corrupt && err_at < 0}, err_at < 0, err_at);
    endtask

    task automatic rx_data(input usb_pkg::usb_pid_e pid, input logic corrupt);
        int n;
        int k;
        n = 1 + (($random(seed) & 32'hff) % 12);
        payload.delete();
        repeat (n) payload.push_back($random(seed));
        build_data(pid);
        if (corrupt) begin
            k = 1 + (($random(seed) & 32'hff) % (n + 2));
            pkt[k] = pkt[k] ^ (8'h1 << ($random(seed) & 7));
        end
        rx_send($sformatf("rx %s len %0d%s", pid.name(), n, corrupt ? " bad crc" : ""),
                '{pid: pid, dev_addr: 7'h0, endp: 4'h0, crc_valid: !corrupt}, 1'b0, -1);
    endtask

    task automatic tx_send(input string name, input usb_pkg::usb_pid_e pid, input logic data);
        u_checker.start_test(name);
        foreach (pkt[i]) begin
            u_checker.expect_tx(pkt[i]);
        end
        @(posedge clk);
        stall_en = 1'b1;
        #1 tx_pid = pid;
        tx_start = 1'b1;
        @(posedge clk);
        #1 tx_start = 1'b0;
        foreach (payload[i]) begin
            tx_payload = '{data: payload[i], valid: 1'b1, eop: data && i == payload.size() - 1};
            do @(posedge clk); while (!tx_payload_ready);
            #1;
        end
        tx_payload = '0;
        // Queue empty and valid low marks the EOP cycle
        while (u_checker.tx_q.size() != 0 || utmi_tx_valid) @(posedge clk);
        stall_en = 1'b0;
        repeat (2) @(posedge clk);
        u_checker.finish_test();
    endtask

    task automatic line_test();
        u_checker.start_test("line monitor");
        @(posedge clk);
        #1 line_state = usb_pkg::LS_SE0;
        for (int k = 1; k <= 200; k++) begin
            @(posedge clk);
            u_checker.check_val("reset_detect", reset_detect, k > usb_pkg::SE0_RESET_CYCLES + 1);
        end
        #1 line_state = usb_pkg::LS_J;
        repeat (2) @(posedge clk);
        u_checker.check_val("reset_detect after J", reset_detect, 0);
        repeat (usb_pkg::SUSPEND_CYCLES + 10) @(posedge clk);
        u_checker.check_val("suspend_detect", suspend_detect, 1);
        #1 line_state = usb_pkg::LS_K;
        @(posedge clk);
        @(posedge clk);
        u_checker.check_val("resume_detect", resume_detect, 1);
        u_checker.check_val("suspend_detect on K", suspend_detect, 0);
        @(posedge clk);
        u_checker.check_val("resume_detect width", resume_detect, 0);
        #1 line_state = usb_pkg::LS_J;
        u_checker.finish_test();
    endtask

    initial begin
        rst_n         = 1'b0;
        utmi_rx       = '0;
        line_state    = usb_pkg::LS_J;
        utmi_tx_ready = 1'b1;
        tx_start      = 1'b0;
        tx_pid        = usb_pkg::PID_ACK;
        tx_payload    = '0;
        repeat (4) @(posedge clk);
        #1 rst_n = 1'b1;

        rx_token(usb_pkg::PID_IN, 1'b0, -1);
        rx_token(usb_pkg::PID_OUT, 1'b0, -1);
        rx_token(usb_pkg::PID_SETUP, 1'b0, -1);
        repeat (3) begin
            rx_data(usb_pkg::PID_DATA0, 1'b0);
            rx_data(usb_pkg::PID_DATA1, 1'b0);
            rx_data(usb_pkg::PID_DATA0, 1'b1);
            rx_data(usb_pkg::PID_DATA1, 1'b1);
        end
        rx_token(usb_pkg::PID_OUT, 1'b1, -1);
        rx_token(usb_pkg::PID_SETUP, 1'b0, 1);   // Error flagged on the address byte

        payload.delete();
        build_data(usb_pkg::PID_ACK);
        pkt = pkt[0:0];                          // Handshake is the PID byte alone
        tx_send("tx ACK", usb_pkg::PID_ACK, 1'b0);

        payload.delete();
        payload.push_back({1'b1, 7'h2a});
        payload.push_back(8'b10101_101);         // High bits replaced by the CRC
        build_token(usb_pkg::PID_IN, 7'h2a, 4'b1011);
        tx_send("tx token IN", usb_pkg::PID_IN, 1'b0);

        for (int p = 0; p < 4; p++) begin
            payload.delete();
            repeat (1 + (($random(seed) & 32'hff) % 12)) payload.push_back($random(seed));
            build_data(p[0] ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0);
            tx_send($sformatf("tx data len %0d", payload.size()),
                    p[0] ? usb_pkg::PID_DATA1 : usb_pkg::PID_DATA0, 1'b1);
        end

        line_test();

        $display("Summary: %0d tests passed, %0d tests failed, %0d errors",
                 u_checker.pass_cnt, u_checker.fail_cnt, u_checker.err_cnt);
        if (u_checker.fail_cnt == 0 && u_checker.err_cnt == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: src.f
logic/usb_pkg.sv
logic/usb_rx_decoder.sv
logic/usb_tx_encoder.sv
logic/usb_line_monitor.sv
logic/usb_protocol_top.sv
testbench/usb_checker.sv
testbench/tb_usb_protocol.sv
